// ==== hw/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               load_i,
    input  logic                               ready_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    alu_out_i,
    input  logic                               br_en_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    rs2_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    u_imm_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    pc_i,
    input  logic                               mem_read_i,
    input  logic                               mem_write_i,
    input  rv32i_pipe_pkg::mem_funct3_u        funct3_i,
    input  rv32i_pipe_pkg::marmux_sel_e        mar_sel_i,
    input  rv32i_pipe_pkg::exefwd_sel_e        exefwd_sel_i,
    input  rv32i_pipe_pkg::memfwd_sel_e        memfwd_sel_i,
    output logic                               valid_o,
    output logic                               ready_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    exe_fwd_o,
    output logic                               br_en_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    u_imm_o,
    output rv32i_pipe_pkg::memfwd_sel_e        memfwd_sel_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    mem_addr_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    mem_wdata_o,
    output logic [rv32i_pipe_pkg::MASK_W-1:0]  mem_byte_en_o
);

    logic [rv32i_pipe_pkg::XLEN-1:0]    exe_fwd_d;
    logic [rv32i_pipe_pkg::XLEN-1:0]    mar_d;
    logic [rv32i_pipe_pkg::XLEN-1:0]    req_addr;
    logic [rv32i_pipe_pkg::MASK_W-1:0]  req_byte_en;
    logic                               mem_access;

    always_comb begin
        case (exefwd_sel_i)
            rv32i_pipe_pkg::exefwd_br_en_zext:
                exe_fwd_d = {{(rv32i_pipe_pkg::XLEN-1){1'b0}}, br_en_i};
            rv32i_pipe_pkg::exefwd_u_imm: exe_fwd_d = u_imm_i;
            default: exe_fwd_d = alu_out_i;
        endcase
    end

    assign mar_d = (mar_sel_i == rv32i_pipe_pkg::marmux_alu_out) ? alu_out_i : pc_i;

    mem_req_gen u_mem_req_gen (
        .addr_i       (mar_d),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .funct3_i     (funct3_i),
        .mem_access_o (mem_access),
        .byte_en_o    (req_byte_en),
        .addr_o       (req_addr)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o      <= 1'b0;
            ready_o      <= 1'b0;
            exe_fwd_o    <= '0;
            br_en_o      <= 1'b0;
            u_imm_o      <= '0;
            memfwd_sel_o <= rv32i_pipe_pkg::memfwd_mem_rdata;
        end else if (load_i) begin
            valid_o      <= 1'b1;
            ready_o      <= ready_i;
            exe_fwd_o    <= exe_fwd_d;
            br_en_o      <= br_en_i;
            u_imm_o      <= u_imm_i;
            memfwd_sel_o <= memfwd_sel_i;
        end
    end

    // request stays primed for the memory stage until the next access
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_addr_o    <= '0;
            mem_wdata_o   <= '0;
            mem_byte_en_o <= '0;
        end else if (load_i && mem_access) begin
            mem_addr_o    <= req_addr;
            mem_wdata_o   <= rs2_i;
            mem_byte_en_o <= req_byte_en;
        end
    end

endmodule

// ==== hw/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load_i,
    input  logic                             ready_i,
    input  logic                             mem_read_i,
    input  logic                             mem_write_i,
    input  rv32i_pipe_pkg::mem_funct3_u      funct3_i,
    input  rv32i_pipe_pkg::marmux_sel_e      mar_sel_i,
    input  rv32i_pipe_pkg::exefwd_sel_e      exefwd_sel_i,
    input  rv32i_pipe_pkg::memfwd_sel_e      memfwd_sel_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]  u_imm_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]  pc_i,
    output logic                             valid_o,
    output logic                             ready_o,
    output logic                             mem_read_o,
    output logic                             mem_write_o,
    output rv32i_pipe_pkg::mem_funct3_u      funct3_o,
    output rv32i_pipe_pkg::marmux_sel_e      mar_sel_o,
    output rv32i_pipe_pkg::exefwd_sel_e      exefwd_sel_o,
    output rv32i_pipe_pkg::memfwd_sel_e      memfwd_sel_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]  u_imm_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]  pc_o
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o      <= 1'b0;
            ready_o      <= 1'b0;
            mem_read_o   <= 1'b0;
            mem_write_o  <= 1'b0;
            funct3_o     <= '0;
            mar_sel_o    <= rv32i_pipe_pkg::marmux_pc_out;
            exefwd_sel_o <= rv32i_pipe_pkg::exefwd_alu_out;
            memfwd_sel_o <= rv32i_pipe_pkg::memfwd_mem_rdata;
            u_imm_o      <= '0;
            pc_o         <= rv32i_pipe_pkg::PC_RESET;
        end else if (load_i) begin
            valid_o      <= 1'b1;
            ready_o      <= ready_i;
            mem_read_o   <= mem_read_i;
            mem_write_o  <= mem_write_i;
            funct3_o     <= funct3_i;
            mar_sel_o    <= mar_sel_i;
            exefwd_sel_o <= exefwd_sel_i;
            memfwd_sel_o <= memfwd_sel_i;
            u_imm_o      <= u_imm_i;
            pc_o         <= pc_i;
        end
    end

    // decode must never hand over a load that is also a store
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        load_i |-> !(mem_read_i && mem_write_i))
        else $error("id_ex_reg: read and write both set on load");

endmodule

// ==== hw/if_id_reg.sv ====
`timescale 1ns/1ps

module if_id_reg (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load_i,
    input  logic                                ready_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]     instr_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]     pc_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]     pc_next_i,
    output logic                                ready_o,
    output logic                                valid_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]     instr_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]     pc_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]     pc_next_o,
    output logic [rv32i_pipe_pkg::ORDER_W-1:0]  commit_order_o
);

    logic [rv32i_pipe_pkg::ORDER_W-1:0] order_cnt; // tag for the next fetch

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_o        <= 1'b0;
            valid_o        <= 1'b0;
            instr_o        <= '0;
            pc_o           <= rv32i_pipe_pkg::PC_RESET;
            pc_next_o      <= '0;
            commit_order_o <= '0;
            order_cnt      <= '0;
        end else if (load_i) begin
            ready_o        <= ready_i;
            valid_o        <= 1'b1; // sticky
            instr_o        <= instr_i;
            pc_o           <= pc_i;
            pc_next_o      <= pc_next_i;
            commit_order_o <= order_cnt;
            order_cnt      <= order_cnt + rv32i_pipe_pkg::ORDER_W'(1);
        end
    end

    // next tag stays one past the last one handed out
    a_order_link: assert property (@(posedge clk) disable iff (rst)
        order_cnt == (valid_o ? commit_order_o + rv32i_pipe_pkg::ORDER_W'(1) : '0))
        else $error("if_id_reg: commit order counter out of step with the tag");

    a_order_step: assert property (@(posedge clk) disable iff (rst)
        load_i && valid_o |=>
        commit_order_o == $past(commit_order_o) + rv32i_pipe_pkg::ORDER_W'(1))
        else $error("if_id_reg: commit order did not advance by one on load");

endmodule

// ==== hw/mem_req_gen.sv ====
`timescale 1ns/1ps

module mem_req_gen (
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    addr_i,
    input  logic                               mem_read_i,
    input  logic                               mem_write_i,
    input  rv32i_pipe_pkg::mem_funct3_u        funct3_i,
    output logic                               mem_access_o,
    output logic [rv32i_pipe_pkg::MASK_W-1:0]  byte_en_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    addr_o
);

    logic                              code_ok;
    logic [rv32i_pipe_pkg::XLEN-1:0]   addr_aligned;

    assign mem_access_o = mem_read_i | mem_write_i;
    assign addr_aligned = {addr_i[rv32i_pipe_pkg::XLEN-1:2], 2'b00};

    always_comb begin
        code_ok   = 1'b1;
        byte_en_o = '0;
        addr_o    = addr_i;
        if (mem_read_i) begin
            case (funct3_i.load)
                rv32i_pipe_pkg::lw: byte_en_o = 4'b1111;
                rv32i_pipe_pkg::lh, rv32i_pipe_pkg::lhu: begin
                    byte_en_o = 4'b0011 << addr_i[1:0];
                    addr_o    = addr_aligned;
                end
                rv32i_pipe_pkg::lb, rv32i_pipe_pkg::lbu: begin
                    byte_en_o = 4'b0001 << addr_i[1:0];
                    addr_o    = addr_aligned;
                end
                default: code_ok = 1'b0;
            endcase
        end else if (mem_write_i) begin
            case (funct3_i.store)
                rv32i_pipe_pkg::sw: byte_en_o = 4'b1111;
                rv32i_pipe_pkg::sh: begin
                    byte_en_o = 4'b0011 << addr_i[1:0];
                    addr_o    = addr_aligned;
                end
                rv32i_pipe_pkg::sb: begin
                    byte_en_o = 4'b0001 << addr_i[1:0];
                    addr_o    = addr_aligned;
                end
                default: code_ok = 1'b0;
            endcase
        end
    end

    always_comb begin
        if (mem_access_o) begin
            assert (code_ok)
                else $error("mem_req_gen: illegal width code %b", funct3_i);
        end
    end

endmodule

// ==== hw/mem_wb_reg.sv ====
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load_i,
    input  logic                             ready_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]  exe_fwd_i,
    input  logic                             br_en_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]  u_imm_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]  mem_rdata_i,
    input  rv32i_pipe_pkg::memfwd_sel_e      memfwd_sel_i,
    input  logic                             wb_fwd_load_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]  wb_fwd_data_i,
    output logic                             valid_o,
    output logic                             ready_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]  mem_fwd_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]  exe_fwd_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]  mem_rdata_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]  u_imm_o,
    output logic                             br_en_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]  wb_fwd_o
);

    logic [rv32i_pipe_pkg::XLEN-1:0] mem_fwd_d;

    assign mem_fwd_d = (memfwd_sel_i == rv32i_pipe_pkg::memfwd_exe_fwd_data) ?
                       exe_fwd_i : mem_rdata_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o     <= 1'b0;
            ready_o     <= 1'b0;
            mem_fwd_o   <= '0;
            exe_fwd_o   <= '0;
            mem_rdata_o <= '0;
            u_imm_o     <= '0;
            br_en_o     <= 1'b0;
        end else if (load_i) begin
            valid_o     <= 1'b1;
            ready_o     <= ready_i;
            mem_fwd_o   <= mem_fwd_d;
            exe_fwd_o   <= exe_fwd_i;
            mem_rdata_o <= mem_rdata_i;
            u_imm_o     <= u_imm_i;
            br_en_o     <= br_en_i;
        end
    end

    // writeback forward, own strobe independent of the stage load
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_fwd_o <= '0;
        end else if (wb_fwd_load_i) begin
            wb_fwd_o <= wb_fwd_data_i;
        end
    end

endmodule

// ==== hw/rv32i_pipe_pkg.sv ====
package rv32i_pipe_pkg;

    localparam int XLEN    = 32;
    localparam int ORDER_W = 64;
    localparam int MASK_W  = 4;

    localparam logic [XLEN-1:0] PC_RESET = 32'h40000000;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    // funct3 field, read as load or store code depending on the access
    typedef union packed {
        load_funct3_e  load;
        store_funct3_e store;
    } mem_funct3_u;

    typedef enum logic {
        marmux_pc_out  = 1'b0,
        marmux_alu_out = 1'b1
    } marmux_sel_e;

    typedef enum logic [1:0] {
        exefwd_alu_out    = 2'b00,
        exefwd_br_en_zext = 2'b01,
        exefwd_u_imm      = 2'b10
    } exefwd_sel_e;

    typedef enum logic {
        memfwd_mem_rdata    = 1'b0,
        memfwd_exe_fwd_data = 1'b1
    } memfwd_sel_e;

endpackage

// ==== hw/rv32i_stage_regs.sv ====
`timescale 1ns/1ps

module rv32i_stage_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               if_id_load_i,
    input  logic                               id_ex_load_i,
    input  logic                               ex_mem_load_i,
    input  logic                               mem_wb_load_i,
    input  logic                               if_id_ready_i,
    input  logic                               id_ex_ready_i,
    input  logic                               ex_mem_ready_i,
    input  logic                               mem_wb_ready_i,
    // fetch
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    instr_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    pc_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    pc_next_i,
    // decode
    input  logic                               mem_read_i,
    input  logic                               mem_write_i,
    input  rv32i_pipe_pkg::mem_funct3_u        funct3_i,
    input  rv32i_pipe_pkg::marmux_sel_e        mar_sel_i,
    input  rv32i_pipe_pkg::exefwd_sel_e        exefwd_sel_i,
    input  rv32i_pipe_pkg::memfwd_sel_e        memfwd_sel_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    u_imm_i,
    // execute
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    alu_out_i,
    input  logic                               br_en_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    rs2_i,
    // memory and writeback
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    mem_rdata_i,
    input  logic                               wb_fwd_load_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]    wb_fwd_data_i,
    output logic                               if_id_valid_o,
    output logic                               if_id_ready_o,
    output logic                               id_ex_valid_o,
    output logic                               id_ex_ready_o,
    output logic                               ex_mem_valid_o,
    output logic                               ex_mem_ready_o,
    output logic                               mem_wb_valid_o,
    output logic                               mem_wb_ready_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    dec_instr_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    dec_pc_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    dec_pc_next_o,
    output logic [rv32i_pipe_pkg::ORDER_W-1:0] commit_order_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    mem_addr_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    mem_wdata_o,
    output logic [rv32i_pipe_pkg::MASK_W-1:0]  mem_byte_en_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    mem_fwd_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    wb_exe_fwd_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    mem_rdata_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    wb_u_imm_o,
    output logic                               wb_br_en_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]    wb_fwd_o
);

    // decode/execute to execute/memory
    logic                              ex_mem_read;
    logic                              ex_mem_write;
    rv32i_pipe_pkg::mem_funct3_u       ex_funct3;
    rv32i_pipe_pkg::marmux_sel_e       ex_mar_sel;
    rv32i_pipe_pkg::exefwd_sel_e       ex_exefwd_sel;
    rv32i_pipe_pkg::memfwd_sel_e       ex_memfwd_sel;
    logic [rv32i_pipe_pkg::XLEN-1:0]   ex_u_imm;
    logic [rv32i_pipe_pkg::XLEN-1:0]   ex_pc;
    // execute/memory to memory/writeback
    logic [rv32i_pipe_pkg::XLEN-1:0]   mem_exe_fwd;
    logic                              mem_br_en;
    logic [rv32i_pipe_pkg::XLEN-1:0]   mem_u_imm;
    rv32i_pipe_pkg::memfwd_sel_e       mem_memfwd_sel;

    if_id_reg u_if_id (
        .clk            (clk),
        .rst            (rst),
        .load_i         (if_id_load_i),
        .ready_i        (if_id_ready_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .pc_next_i      (pc_next_i),
        .ready_o        (if_id_ready_o),
        .valid_o        (if_id_valid_o),
        .instr_o        (dec_instr_o),
        .pc_o           (dec_pc_o),
        .pc_next_o      (dec_pc_next_o),
        .commit_order_o (commit_order_o)
    );

    id_ex_reg u_id_ex (
        .clk          (clk),
        .rst          (rst),
        .load_i       (id_ex_load_i),
        .ready_i      (id_ex_ready_i),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .funct3_i     (funct3_i),
        .mar_sel_i    (mar_sel_i),
        .exefwd_sel_i (exefwd_sel_i),
        .memfwd_sel_i (memfwd_sel_i),
        .u_imm_i      (u_imm_i),
        .pc_i         (dec_pc_o),
        .valid_o      (id_ex_valid_o),
        .ready_o      (id_ex_ready_o),
        .mem_read_o   (ex_mem_read),
        .mem_write_o  (ex_mem_write),
        .funct3_o     (ex_funct3),
        .mar_sel_o    (ex_mar_sel),
        .exefwd_sel_o (ex_exefwd_sel),
        .memfwd_sel_o (ex_memfwd_sel),
        .u_imm_o      (ex_u_imm),
        .pc_o         (ex_pc)
    );

    ex_mem_reg u_ex_mem (
        .clk           (clk),
        .rst           (rst),
        .load_i        (ex_mem_load_i),
        .ready_i       (ex_mem_ready_i),
        .alu_out_i     (alu_out_i),
        .br_en_i       (br_en_i),
        .rs2_i         (rs2_i),
        .u_imm_i       (ex_u_imm),
        .pc_i          (ex_pc),
        .mem_read_i    (ex_mem_read),
        .mem_write_i   (ex_mem_write),
        .funct3_i      (ex_funct3),
        .mar_sel_i     (ex_mar_sel),
        .exefwd_sel_i  (ex_exefwd_sel),
        .memfwd_sel_i  (ex_memfwd_sel),
        .valid_o       (ex_mem_valid_o),
        .ready_o       (ex_mem_ready_o),
        .exe_fwd_o     (mem_exe_fwd),
        .br_en_o       (mem_br_en),
        .u_imm_o       (mem_u_imm),
        .memfwd_sel_o  (mem_memfwd_sel),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_byte_en_o (mem_byte_en_o)
    );

    mem_wb_reg u_mem_wb (
        .clk           (clk),
        .rst           (rst),
        .load_i        (mem_wb_load_i),
        .ready_i       (mem_wb_ready_i),
        .exe_fwd_i     (mem_exe_fwd),
        .br_en_i       (mem_br_en),
        .u_imm_i       (mem_u_imm),
        .mem_rdata_i   (mem_rdata_i),
        .memfwd_sel_i  (mem_memfwd_sel),
        .wb_fwd_load_i (wb_fwd_load_i),
        .wb_fwd_data_i (wb_fwd_data_i),
        .valid_o       (mem_wb_valid_o),
        .ready_o       (mem_wb_ready_o),
        .mem_fwd_o     (mem_fwd_o),
        .exe_fwd_o     (wb_exe_fwd_o),
        .mem_rdata_o   (mem_rdata_o),
        .u_imm_o       (wb_u_imm_o),
        .br_en_o       (wb_br_en_o),
        .wb_fwd_o      (wb_fwd_o)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_rv32i_stage_regs \
    -f rv32i_stage_regs.f \
    -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// ==== rv32i_stage_regs.f ====
hw/rv32i_pipe_pkg.sv
hw/if_id_reg.sv
hw/id_ex_reg.sv
hw/mem_req_gen.sv
hw/ex_mem_reg.sv
hw/mem_wb_reg.sv
hw/rv32i_stage_regs.sv
verif/tb_rv32i_stage_regs.sv

// ==== verif/tb_rv32i_stage_regs.sv ====
`timescale 1ns/1ps

module tb_rv32i_stage_regs;

    localparam int PHASE_CYCLES   = 300;
    localparam int TIMEOUT_CYCLES = 3000; // six phases plus reset and margin
    localparam int LOAD_MODE [6]  = '{0, 1, 2, 1, 2, 0};

    logic        clk;
    logic        rst;
    logic        if_id_load_i, id_ex_load_i, ex_mem_load_i, mem_wb_load_i;
    logic        if_id_ready_i, id_ex_ready_i, ex_mem_ready_i, mem_wb_ready_i;
    logic        mem_read_i, mem_write_i, br_en_i, wb_fwd_load_i;
    logic [31:0] instr_i, pc_i, pc_next_i, u_imm_i, alu_out_i, rs2_i;
    logic [31:0] mem_rdata_i, wb_fwd_data_i;
    rv32i_pipe_pkg::mem_funct3_u funct3_i;
    rv32i_pipe_pkg::marmux_sel_e mar_sel_i;
    rv32i_pipe_pkg::exefwd_sel_e exefwd_sel_i;
    rv32i_pipe_pkg::memfwd_sel_e memfwd_sel_i;

    logic        if_id_valid_o, if_id_ready_o, id_ex_valid_o, id_ex_ready_o;
    logic        ex_mem_valid_o, ex_mem_ready_o, mem_wb_valid_o, mem_wb_ready_o;
    logic        wb_br_en_o;
    logic [31:0] dec_instr_o, dec_pc_o, dec_pc_next_o, mem_addr_o, mem_wdata_o;
    logic [31:0] mem_fwd_o, wb_exe_fwd_o, mem_rdata_o, wb_u_imm_o, wb_fwd_o;
    logic [63:0] commit_order_o;
    logic [3:0]  mem_byte_en_o;
    logic [7:0]  dut_flags;

    // reference model, one group per stage register
    logic [7:0]  m_flags; // valid/ready pairs, if_id in the top bits
    logic [31:0] m_instr, m_pc, m_pc_next;
    logic [63:0] m_order, m_order_cnt;
    logic        m_rd, m_wr, m_mar, m_memsel;
    logic [2:0]  m_f3;
    logic [1:0]  m_exesel;
    logic [31:0] m_ex_uimm, m_ex_pc;
    logic        m_br_en, m_mem_memsel;
    logic [31:0] m_exe_fwd, m_mem_uimm, m_addr, m_wdata;
    logic [3:0]  m_be;
    logic        m_wb_br_en;
    logic [31:0] m_mem_fwd, m_wb_exe_fwd, m_rdata, m_wb_uimm, m_wb_fwd;

    logic [31:0] lfsr = 32'he0809ad6;
    int          cycles = 0;

    rv32i_stage_regs dut0 (.*);

    assign dut_flags = {if_id_valid_o, if_id_ready_o, id_ex_valid_o, id_ex_ready_o,
                        ex_mem_valid_o, ex_mem_ready_o, mem_wb_valid_o, mem_wb_ready_o};

    // fibonacci, taps 32 22 2 1
    function automatic logic rand_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        int          i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            w = {w[30:0], rand_bit()};
        end
        return w;
    endfunction

    function automatic logic load_bit(input int mode);
        case (mode)
            0: return 1'b1;
            1: return rand_bit();
            default: return rand_bit() & rand_bit(); // sparse loads, mostly holding
        endcase
    endfunction

    // byte enable and address of an access, {byte_en, addr}
    function automatic logic [35:0] expect_req(input logic [31:0] a, input logic [2:0] f3);
        logic [3:0]  be;
        logic [31:0] adr;
        adr = {a[31:2], 2'b00};
        case (f3[1:0])
            2'd2: begin
                be  = 4'b1111;
                adr = a;
            end
            2'd1: be = 4'b0011 << a[1:0];
            default: be = 4'b0001 << a[1:0];
        endcase
        return {be, adr};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_fail(input string test, input logic [63:0] exp, input logic [63:0] act);
        abort_run($sformatf("FAIL %s expected %0h actual %0h", test, exp, act));
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the stimulus did not finish within the cycle limit");
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            {m_flags, m_instr, m_pc_next, m_order, m_order_cnt, m_rd, m_wr, m_mar, m_memsel,
             m_f3, m_exesel, m_ex_uimm, m_br_en, m_mem_memsel, m_exe_fwd, m_mem_uimm, m_addr,
             m_wdata, m_be, m_wb_br_en, m_mem_fwd, m_wb_exe_fwd, m_rdata, m_wb_uimm,
             m_wb_fwd} <= '0;
            m_pc    <= rv32i_pipe_pkg::PC_RESET;
            m_ex_pc <= rv32i_pipe_pkg::PC_RESET;
        end else begin
            if (if_id_load_i) begin
                m_flags[7:6] <= {1'b1, if_id_ready_i};
                m_instr      <= instr_i;
                m_pc         <= pc_i;
                m_pc_next    <= pc_next_i;
                m_order      <= m_order_cnt; // number of earlier loads
                m_order_cnt  <= m_order_cnt + 64'd1;
            end
            if (id_ex_load_i) begin
                m_flags[5:4] <= {1'b1, id_ex_ready_i};
                {m_rd, m_wr, m_f3} <= {mem_read_i, mem_write_i, funct3_i};
                {m_mar, m_exesel, m_memsel} <= {mar_sel_i, exefwd_sel_i, memfwd_sel_i};
                m_ex_uimm    <= u_imm_i;
                m_ex_pc      <= m_pc;
            end
            if (ex_mem_load_i) begin
                m_flags[3:2] <= {1'b1, ex_mem_ready_i};
                case (m_exesel)
                    2'd1: m_exe_fwd <= 32'(br_en_i);
                    2'd2: m_exe_fwd <= m_ex_uimm;
                    default: m_exe_fwd <= alu_out_i;
                endcase
                m_br_en      <= br_en_i;
                m_mem_uimm   <= m_ex_uimm;
                m_mem_memsel <= m_memsel;
                if (m_rd || m_wr) begin
                    {m_be, m_addr} <= expect_req(m_mar ? alu_out_i : m_ex_pc, m_f3);
                    m_wdata        <= rs2_i;
                end
            end
            if (mem_wb_load_i) begin
                m_flags[1:0] <= {1'b1, mem_wb_ready_i};
                m_mem_fwd    <= m_mem_memsel ? m_exe_fwd : mem_rdata_i;
                m_wb_exe_fwd <= m_exe_fwd;
                m_rdata      <= mem_rdata_i;
                m_wb_uimm    <= m_mem_uimm;
                m_wb_br_en   <= m_br_en;
            end
            if (wb_fwd_load_i) begin
                m_wb_fwd <= wb_fwd_data_i;
            end
        end
    end

    a_reset: assert property (@(posedge clk) $fell(rst) |->
        dec_pc_o == rv32i_pipe_pkg::PC_RESET && dut_flags == '0 && commit_order_o == '0 &&
        {dec_instr_o, dec_pc_next_o, mem_addr_o, mem_wdata_o, mem_byte_en_o} == '0 &&
        {mem_fwd_o, wb_exe_fwd_o, mem_rdata_o, wb_u_imm_o, wb_br_en_o, wb_fwd_o} == '0)
        else abort_run("outputs were not in their reset state after reset");
    a_sticky: assert property (@(posedge clk) disable iff (rst) !($fell(if_id_valid_o) ||
        $fell(id_ex_valid_o) || $fell(ex_mem_valid_o) || $fell(mem_wb_valid_o)))
        else abort_run("a valid output dropped after it was set");
    a_flags: assert property (@(posedge clk) disable iff (rst) dut_flags == m_flags)
        else check_fail("valid_ready", 64'($sampled(m_flags)), 64'($sampled(dut_flags)));
    a_instr: assert property (@(posedge clk) disable iff (rst) dec_instr_o == m_instr)
        else check_fail("if_id_instr", 64'($sampled(m_instr)), 64'($sampled(dec_instr_o)));
    a_pc: assert property (@(posedge clk) disable iff (rst) dec_pc_o == m_pc)
        else check_fail("if_id_pc", 64'($sampled(m_pc)), 64'($sampled(dec_pc_o)));
    a_pc_next: assert property (@(posedge clk) disable iff (rst) dec_pc_next_o == m_pc_next)
        else check_fail("if_id_pc_next", 64'($sampled(m_pc_next)), 64'($sampled(dec_pc_next_o)));
    a_order: assert property (@(posedge clk) disable iff (rst) commit_order_o == m_order)
        else check_fail("commit_order", $sampled(m_order), $sampled(commit_order_o));
    a_addr: assert property (@(posedge clk) disable iff (rst) mem_addr_o == m_addr)
        else check_fail("mem_addr", 64'($sampled(m_addr)), 64'($sampled(mem_addr_o)));
    a_wdata: assert property (@(posedge clk) disable iff (rst) mem_wdata_o == m_wdata)
        else check_fail("mem_wdata", 64'($sampled(m_wdata)), 64'($sampled(mem_wdata_o)));
    a_be: assert property (@(posedge clk) disable iff (rst) mem_byte_en_o == m_be)
        else check_fail("mem_byte_en", 64'($sampled(m_be)), 64'($sampled(mem_byte_en_o)));
    a_mem_fwd: assert property (@(posedge clk) disable iff (rst) mem_fwd_o == m_mem_fwd)
        else check_fail("mem_fwd", 64'($sampled(m_mem_fwd)), 64'($sampled(mem_fwd_o)));
    a_exe_fwd: assert property (@(posedge clk) disable iff (rst) wb_exe_fwd_o == m_wb_exe_fwd)
        else check_fail("exe_fwd", 64'($sampled(m_wb_exe_fwd)), 64'($sampled(wb_exe_fwd_o)));
    a_rdata: assert property (@(posedge clk) disable iff (rst) mem_rdata_o == m_rdata)
        else check_fail("wb_rdata", 64'($sampled(m_rdata)), 64'($sampled(mem_rdata_o)));
    a_u_imm: assert property (@(posedge clk) disable iff (rst) wb_u_imm_o == m_wb_uimm)
        else check_fail("wb_u_imm", 64'($sampled(m_wb_uimm)), 64'($sampled(wb_u_imm_o)));
    a_br_en: assert property (@(posedge clk) disable iff (rst) wb_br_en_o == m_wb_br_en)
        else check_fail("wb_br_en", 64'($sampled(m_wb_br_en)), 64'($sampled(wb_br_en_o)));
    a_wb_fwd: assert property (@(posedge clk) disable iff (rst) wb_fwd_o == m_wb_fwd)
        else check_fail("wb_fwd", 64'($sampled(m_wb_fwd)), 64'($sampled(wb_fwd_o)));

    initial begin
        logic [1:0] w2;
        logic       rd;
        int         p;
        rst = 1'b1;
        {if_id_load_i, id_ex_load_i, ex_mem_load_i, mem_wb_load_i, wb_fwd_load_i} = '0;
        {if_id_ready_i, id_ex_ready_i, ex_mem_ready_i, mem_wb_ready_i} = '0;
        {mem_read_i, mem_write_i, br_en_i} = '0;
        {instr_i, pc_i, pc_next_i, u_imm_i, alu_out_i, rs2_i} = '0;
        {mem_rdata_i, wb_fwd_data_i} = '0;
        funct3_i     = '0;
        mar_sel_i    = rv32i_pipe_pkg::marmux_pc_out;
        exefwd_sel_i = rv32i_pipe_pkg::exefwd_alu_out;
        memfwd_sel_i = rv32i_pipe_pkg::memfwd_mem_rdata;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (p = 0; p < 6; p++) begin
            repeat (PHASE_CYCLES) begin
                @(posedge clk);
                if_id_load_i   <= load_bit(LOAD_MODE[p]);
                id_ex_load_i   <= load_bit(LOAD_MODE[p]);
                ex_mem_load_i  <= load_bit(LOAD_MODE[p]);
                mem_wb_load_i  <= load_bit(LOAD_MODE[p]);
                wb_fwd_load_i  <= rand_bit();
                if_id_ready_i  <= rand_bit();
                id_ex_ready_i  <= rand_bit();
                ex_mem_ready_i <= rand_bit();
                mem_wb_ready_i <= rand_bit();
                instr_i        <= rand_word();
                pc_i           <= rand_word();
                pc_next_i      <= rand_word();
                rd = rand_bit();
                mem_read_i     <= rd;
                mem_write_i    <= !rd && rand_bit(); // never both
                w2 = {rand_bit(), rand_bit()};
                w2 = (w2 == 2'd3) ? 2'd2 : w2;
                funct3_i       <= {rd && w2 != 2'd2 && rand_bit(), w2}; // legal codes only
                mar_sel_i      <= rv32i_pipe_pkg::marmux_sel_e'(rand_bit());
                w2 = {rand_bit(), rand_bit()};
                exefwd_sel_i   <= rv32i_pipe_pkg::exefwd_sel_e'((w2 == 2'd3) ? 2'd0 : w2);
                memfwd_sel_i   <= rv32i_pipe_pkg::memfwd_sel_e'(rand_bit());
                u_imm_i        <= rand_word() & 32'hfffff000;
                alu_out_i      <= rand_word();
                br_en_i        <= rand_bit();
                rs2_i          <= rand_word();
                mem_rdata_i    <= rand_word();
                wb_fwd_data_i  <= rand_word();
            end
        end
        @(posedge clk);
        {if_id_load_i, id_ex_load_i, ex_mem_load_i, mem_wb_load_i, wb_fwd_load_i} <= '0;
        repeat (4) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
